//--- design/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// ##################################################
// opcode values, instr[15:11]
// ##################################################
`define OP_HALT   5'b00000
`define OP_NOP    5'b00001
`define OP_J      5'b00100
`define OP_JR     5'b00101
`define OP_ADDI   5'b01000
`define OP_SUBI   5'b01001
`define OP_XORI   5'b01010
`define OP_ANDNI  5'b01011
`define OP_BEQZ   5'b01100
`define OP_BNEZ   5'b01101
`define OP_ST     5'b10000
`define OP_LD     5'b10001
`define OP_SLBI   5'b10010
`define OP_LBI    5'b11000
`define OP_RTYPE  5'b11011
`define OP_SEQ    5'b11100
`define OP_SLT    5'b11101

// func field of the R-type group, instr[1:0]
`define FUNC_ADD  2'b00
`define FUNC_SUB  2'b01
`define FUNC_XOR  2'b10
`define FUNC_ANDN 2'b11

// ##################################################
// instruction field positions
// ##################################################
`define OP_HI     15
`define OP_LO     11
`define RS_HI     10
`define RS_LO     8
`define RT_HI     7
`define RT_LO     5
`define RD_HI     4
`define RD_LO     2
`define FUNC_HI   1
`define FUNC_LO   0

`define DMEM_WORDS     256
`define DMEM_ADDR_BITS 8

`endif

//--- design/cpuPkg.sv
package cpuPkg;

    typedef logic [15:0] word_t;    // data and instruction word
    typedef logic [2:0]  regSel_t;  // one of eight registers
    typedef logic [4:0]  opcode_t;

    // operation applied after the operand inversions
    typedef enum logic [1:0] {
        ALU_ADD   = 2'b00,
        ALU_XOR   = 2'b01,
        ALU_ANDN  = 2'b10,
        ALU_PASSB = 2'b11
    } aluOp_t;

    typedef enum logic [1:0] {
        IMM_NONE = 2'b00,
        IMM_I1   = 2'b01,  // 5-bit field
        IMM_I2   = 2'b10,  // 8-bit field
        IMM_J    = 2'b11   // 11-bit displacement
    } immFmt_t;

    typedef enum logic [1:0] {
        WR_RS = 2'b00,  // bits 10:8
        WR_RT = 2'b01,  // bits 7:5
        WR_RD = 2'b10   // bits 4:2
    } wrSel_t;

    typedef enum logic [1:0] {
        SET_NONE = 2'b00,
        SET_EQ   = 2'b01,
        SET_LT   = 2'b10
    } setOp_t;

endpackage

//--- design/regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic            clk,
    input  logic            rst,
    input  cpuPkg::regSel_t read1Sel,
    input  cpuPkg::regSel_t read2Sel,
    input  cpuPkg::regSel_t writeSel,
    input  logic            write,
    input  cpuPkg::word_t   writeData,
    output cpuPkg::word_t   read1Data,
    output cpuPkg::word_t   read2Data
);

    cpuPkg::word_t regs [8];  // r0 holds data like any other register

    // ##################################################
    // write port
    // ##################################################
    always_ff @(posedge clk) begin
        if (!rst && write) begin
            regs[writeSel] <= writeData;  // no writes land while reset is held
        end
    end

    // ##################################################
    // read ports
    // ##################################################
    // a same-cycle write is seen only after the edge
    assign read1Data = regs[read1Sel];
    assign read2Data = regs[read2Sel];

endmodule

//--- design/controlUnit.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module controlUnit (
    input  cpuPkg::opcode_t  opcode,
    input  logic [1:0]       func,
    output cpuPkg::aluOp_t   aluOp,
    output logic             aluSrc,
    output logic             invA,
    output logic             invB,
    output logic             cin,
    output cpuPkg::setOp_t   setOp,
    output logic             branch,
    output logic             branchNez,
    output logic             jump,
    output logic             jumpReg,
    output logic             memWrite,
    output logic             memRead,
    output logic             memToReg,
    output logic             regWrite,
    output cpuPkg::immFmt_t  immFmt,
    output logic             zeroExt,
    output cpuPkg::wrSel_t   wrSel,
    output logic             halt,
    output logic             illegal
);

    always_comb begin
        aluOp     = cpuPkg::ALU_ADD;
        aluSrc    = 1'b0;
        invA      = 1'b0;
        invB      = 1'b0;
        cin       = 1'b0;
        setOp     = cpuPkg::SET_NONE;
        branch    = 1'b0;
        branchNez = 1'b0;
        jump      = 1'b0;
        jumpReg   = 1'b0;
        memWrite  = 1'b0;
        memRead   = 1'b0;
        memToReg  = 1'b0;
        regWrite  = 1'b0;
        immFmt    = cpuPkg::IMM_NONE;
        zeroExt   = 1'b0;
        wrSel     = cpuPkg::WR_RT;
        halt      = 1'b0;
        illegal   = 1'b0;

        case (opcode)
            `OP_HALT: halt = 1'b1;
            `OP_NOP: ;
            // ##################################################
            // immediate arithmetic, result goes to bits 7:5
            // ##################################################
            `OP_ADDI, `OP_SUBI, `OP_XORI, `OP_ANDNI: begin
                aluSrc   = 1'b1;
                immFmt   = cpuPkg::IMM_I1;
                regWrite = 1'b1;
                if (opcode == `OP_SUBI) begin
                    invA = 1'b1;  // imm + ~rs + 1 gives imm - rs
                    cin  = 1'b1;
                end
                if (opcode == `OP_XORI) aluOp = cpuPkg::ALU_XOR;
                if (opcode == `OP_ANDNI) begin
                    aluOp   = cpuPkg::ALU_ANDN;
                    zeroExt = 1'b1;
                end
            end
            `OP_ST, `OP_LD: begin
                aluSrc = 1'b1;  // address is rs + imm5
                immFmt = cpuPkg::IMM_I1;
                if (opcode == `OP_ST) begin
                    memWrite = 1'b1;
                end else begin
                    memRead  = 1'b1;
                    memToReg = 1'b1;
                    regWrite = 1'b1;
                end
            end
            `OP_LBI, `OP_SLBI: begin
                aluOp    = cpuPkg::ALU_PASSB;
                aluSrc   = 1'b1;
                immFmt   = cpuPkg::IMM_I2;
                zeroExt  = (opcode == `OP_SLBI);  // decode merges rs into the SLBI value
                wrSel    = cpuPkg::WR_RS;
                regWrite = 1'b1;
            end
            // ##################################################
            // control transfer
            // ##################################################
            `OP_BEQZ, `OP_BNEZ: begin
                branch    = 1'b1;
                branchNez = (opcode == `OP_BNEZ);
                immFmt    = cpuPkg::IMM_I2;
            end
            `OP_J: begin
                jump   = 1'b1;
                immFmt = cpuPkg::IMM_J;
            end
            `OP_JR: begin
                jumpReg = 1'b1;
                immFmt  = cpuPkg::IMM_I2;
            end
            // ##################################################
            // register-register group, result goes to bits 4:2
            // ##################################################
            `OP_RTYPE: begin
                wrSel    = cpuPkg::WR_RD;
                regWrite = 1'b1;
                case (func)
                    `FUNC_ADD: aluOp = cpuPkg::ALU_ADD;
                    `FUNC_SUB: begin
                        invA = 1'b1;  // rt - rs
                        cin  = 1'b1;
                    end
                    `FUNC_XOR: aluOp = cpuPkg::ALU_XOR;
                    default: aluOp = cpuPkg::ALU_ANDN;
                endcase
            end
            `OP_SEQ, `OP_SLT: begin
                invB     = 1'b1;  // adder forms rs - rt for both compares
                cin      = 1'b1;
                setOp    = (opcode == `OP_SEQ) ? cpuPkg::SET_EQ : cpuPkg::SET_LT;
                wrSel    = cpuPkg::WR_RD;
                regWrite = 1'b1;
            end
            default: illegal = 1'b1;  // all write enables stay low
        endcase
    end

endmodule

//--- design/decode.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module decode (
    input  logic            clk,
    input  logic            rst,
    input  cpuPkg::word_t   Instr,
    input  cpuPkg::word_t   WriteData,
    output cpuPkg::word_t   ALUOp1,
    output cpuPkg::word_t   ALUOp2,
    output cpuPkg::word_t   Immediate,
    output logic            ALUSrc,
    output cpuPkg::aluOp_t  ALUOpcode,
    output logic            InvA,
    output logic            InvB,
    output logic            Cin,
    output cpuPkg::setOp_t  SetOp,
    output logic            Branch,
    output logic            BranchNez,
    output logic            Jump,
    output logic            JumpReg,
    output logic            MemWrite,
    output logic            MemRead,
    output logic            MemToReg,
    output logic            RegWriteEn,
    output cpuPkg::regSel_t RegWriteSel,
    output logic            Halt,
    output logic            Err
);

    cpuPkg::immFmt_t immFmt;
    cpuPkg::wrSel_t  wrSel;
    logic            zeroExt;

    regFile regs (
        .clk       (clk),
        .rst       (rst),
        .read1Sel  (Instr[`RS_HI:`RS_LO]),
        .read2Sel  (Instr[`RT_HI:`RT_LO]),
        .writeSel  (RegWriteSel),
        .write     (RegWriteEn),
        .writeData (WriteData),
        .read1Data (ALUOp1),
        .read2Data (ALUOp2)
    );

    always_comb begin
        case (wrSel)
            cpuPkg::WR_RS: RegWriteSel = Instr[`RS_HI:`RS_LO];
            cpuPkg::WR_RD: RegWriteSel = Instr[`RD_HI:`RD_LO];
            default:       RegWriteSel = Instr[`RT_HI:`RT_LO];
        endcase
    end

    // ##################################################
    // immediate extension
    // ##################################################
    always_comb begin
        case (immFmt)
            cpuPkg::IMM_I1: Immediate = zeroExt ? {11'b0, Instr[4:0]} : {{11{Instr[4]}}, Instr[4:0]};
            cpuPkg::IMM_I2: begin
                if (zeroExt) Immediate = {ALUOp1[7:0], Instr[7:0]};  // SLBI, (rs << 8) | imm8
                else         Immediate = {{8{Instr[7]}}, Instr[7:0]};
            end
            cpuPkg::IMM_J:  Immediate = {{5{Instr[10]}}, Instr[10:0]};
            default:        Immediate = '0;
        endcase
    end

    controlUnit ctrl (
        .opcode    (Instr[`OP_HI:`OP_LO]),
        .func      (Instr[`FUNC_HI:`FUNC_LO]),
        .aluOp     (ALUOpcode),
        .aluSrc    (ALUSrc),
        .invA      (InvA),
        .invB      (InvB),
        .cin       (Cin),
        .setOp     (SetOp),
        .branch    (Branch),
        .branchNez (BranchNez),
        .jump      (Jump),
        .jumpReg   (JumpReg),
        .memWrite  (MemWrite),
        .memRead   (MemRead),
        .memToReg  (MemToReg),
        .regWrite  (RegWriteEn),
        .immFmt    (immFmt),
        .zeroExt   (zeroExt),
        .wrSel     (wrSel),
        .halt      (Halt),
        .illegal   (Err)
    );

endmodule

//--- design/aluExec.sv
`timescale 1ns/1ns

module aluExec (
    input  cpuPkg::word_t  ALUOp1,
    input  cpuPkg::word_t  ALUOp2,
    input  cpuPkg::word_t  Immediate,
    input  cpuPkg::word_t  Pc,
    input  logic           ALUSrc,
    input  logic           InvA,
    input  logic           InvB,
    input  logic           Cin,
    input  logic           Branch,
    input  logic           BranchNez,
    input  logic           Jump,
    input  logic           JumpReg,
    input  cpuPkg::aluOp_t ALUOpcode,
    input  cpuPkg::setOp_t SetOp,
    output cpuPkg::word_t  AluResult,
    output cpuPkg::word_t  Target,
    output logic           Taken
);

    cpuPkg::word_t opA;
    cpuPkg::word_t opB;
    cpuPkg::word_t sum;
    cpuPkg::word_t opResult;
    logic          overflow;
    logic          lessThan;
    logic          rsZero;

    // ##################################################
    // operands and ALU
    // ##################################################
    assign opA = InvA ? ~ALUOp1 : ALUOp1;
    assign opB = InvB ? ~(ALUSrc ? Immediate : ALUOp2) : (ALUSrc ? Immediate : ALUOp2);
    assign sum = opA + opB + {15'b0, Cin};

    always_comb begin
        case (ALUOpcode)
            cpuPkg::ALU_XOR:  opResult = opA ^ opB;
            cpuPkg::ALU_ANDN: opResult = opA & ~opB;
            cpuPkg::ALU_PASSB: opResult = opB;
            default:          opResult = sum;
        endcase
    end

    // sum holds rs - rt when a compare is decoded
    assign overflow = (opA[15] == opB[15]) && (sum[15] != opA[15]);
    assign lessThan = sum[15] ^ overflow;

    always_comb begin
        case (SetOp)
            cpuPkg::SET_EQ: AluResult = {15'b0, (sum == '0)};
            cpuPkg::SET_LT: AluResult = {15'b0, lessThan};
            default:        AluResult = opResult;
        endcase
    end

    // ##################################################
    // branches and jumps
    // ##################################################
    assign rsZero = (ALUOp1 == '0);
    assign Taken  = Jump | JumpReg | (Branch & (rsZero ^ BranchNez));
    assign Target = JumpReg ? ALUOp1 + Immediate : Pc + 16'd2 + Immediate;  // JR is register-relative

endmodule

//--- design/memStage.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module memStage (
    input  logic          clk,
    input  logic          MemWrite,
    input  logic          MemRead,
    input  logic          MemToReg,
    input  cpuPkg::word_t AluResult,
    input  cpuPkg::word_t StoreData,
    output cpuPkg::word_t RegWriteData
);

    cpuPkg::word_t mem [`DMEM_WORDS];

    logic [`DMEM_ADDR_BITS-1:0] wordAddr;
    cpuPkg::word_t              loadData;

    assign wordAddr = AluResult[`DMEM_ADDR_BITS:1];  // byte address, bit 0 dropped

    // ##################################################
    // data memory
    // ##################################################
    always_ff @(posedge clk) begin
        if (MemWrite) begin
            mem[wordAddr] <= StoreData;
        end
    end

    assign loadData = MemRead ? mem[wordAddr] : '0;

    // ##################################################
    // writeback select
    // ##################################################
    assign RegWriteData = MemToReg ? loadData : AluResult;

endmodule

//--- design/pcUnit.sv
`timescale 1ns/1ns

module pcUnit (
    input  logic          clk,
    input  logic          rst,
    input  logic          Halt,
    input  logic          Err,
    input  logic          Taken,
    input  cpuPkg::word_t Target,
    output cpuPkg::word_t Pc
);

    cpuPkg::word_t pcReg;
    cpuPkg::word_t nextPc;

    assign nextPc = Taken ? Target : pcReg + 16'd2;

    always_ff @(posedge clk) begin
        if (rst) begin
            pcReg <= '0;
        end else if (!(Halt || Err)) begin
            pcReg <= nextPc;  // frozen on halt or an illegal opcode
        end
    end

    assign Pc = pcReg;

endmodule

//--- design/cpuTop.sv
`timescale 1ns/1ns

module cpuTop (
    input  logic            clk,
    input  logic            rst,
    input  cpuPkg::word_t   Instr,
    output cpuPkg::word_t   Pc,
    output logic            Halt,
    output logic            Err,
    output logic            RegWriteEn,
    output cpuPkg::regSel_t RegWriteSel,
    output cpuPkg::word_t   RegWriteData
);

    cpuPkg::word_t  aluOp1;
    cpuPkg::word_t  aluOp2;
    cpuPkg::word_t  immediate;
    cpuPkg::word_t  aluResult;
    cpuPkg::word_t  target;
    cpuPkg::aluOp_t aluOpcode;
    cpuPkg::setOp_t setOp;
    logic           aluSrc;
    logic           invA;
    logic           invB;
    logic           cin;
    logic           branch;
    logic           branchNez;
    logic           jump;
    logic           jumpReg;
    logic           memWrite;
    logic           memRead;
    logic           memToReg;
    logic           taken;

    // ##################################################
    // fetch address
    // ##################################################
    pcUnit pcu (
        .clk    (clk),
        .rst    (rst),
        .Halt   (Halt),
        .Err    (Err),
        .Taken  (taken),
        .Target (target),
        .Pc     (Pc)
    );

    decode dec (
        .clk         (clk),
        .rst         (rst),
        .Instr       (Instr),
        .WriteData   (RegWriteData),
        .ALUOp1      (aluOp1),
        .ALUOp2      (aluOp2),
        .Immediate   (immediate),
        .ALUSrc      (aluSrc),
        .ALUOpcode   (aluOpcode),
        .InvA        (invA),
        .InvB        (invB),
        .Cin         (cin),
        .SetOp       (setOp),
        .Branch      (branch),
        .BranchNez   (branchNez),
        .Jump        (jump),
        .JumpReg     (jumpReg),
        .MemWrite    (memWrite),
        .MemRead     (memRead),
        .MemToReg    (memToReg),
        .RegWriteEn  (RegWriteEn),
        .RegWriteSel (RegWriteSel),
        .Halt        (Halt),
        .Err         (Err)
    );

    aluExec exec (
        .ALUOp1    (aluOp1),
        .ALUOp2    (aluOp2),
        .Immediate (immediate),
        .Pc        (Pc),
        .ALUSrc    (aluSrc),
        .InvA      (invA),
        .InvB      (invB),
        .Cin       (cin),
        .Branch    (branch),
        .BranchNez (branchNez),
        .Jump      (jump),
        .JumpReg   (jumpReg),
        .ALUOpcode (aluOpcode),
        .SetOp     (setOp),
        .AluResult (aluResult),
        .Target    (target),
        .Taken     (taken)
    );

    // store data is the register at bits 7:5
    memStage mem (
        .clk          (clk),
        .MemWrite     (memWrite),
        .MemRead      (memRead),
        .MemToReg     (memToReg),
        .AluResult    (aluResult),
        .StoreData    (aluOp2),
        .RegWriteData (RegWriteData)
    );

endmodule

//--- sim/cpuTop_chk.sv
`timescale 1ns/1ns

module cpuTop_chk (
    input logic          clk,
    input logic          rst,
    input cpuPkg::word_t Pc,
    input logic          Halt,
    input logic          Err,
    input logic          RegWriteEn
);

    // ##################################################
    // program counter rules
    // ##################################################
    pcAfterReset: assert property (@(posedge clk) rst |=> (Pc == '0))
        else $error("pc is not zero after reset");

    pcFrozen: assert property (@(posedge clk) ((Halt || Err) && !rst) |=> $stable(Pc))
        else $error("pc moved while halt or err was set");

    pcEven: assert property (@(posedge clk) !rst |-> (Pc[0] == 1'b0))
        else $error("pc is odd");

    // an illegal opcode must not reach the register file
    noWriteOnErr: assert property (@(posedge clk) !(RegWriteEn && Err))
        else $error("register write enabled together with err");

endmodule

bind cpuTop cpuTop_chk chk (
    .clk        (clk),
    .rst        (rst),
    .Pc         (Pc),
    .Halt       (Halt),
    .Err        (Err),
    .RegWriteEn (RegWriteEn)
);

//--- sim/cpuTop_tb.sv
`timescale 1ns/1ns
`include "cpu_consts.svh"

module cpuTop_tb;

    localparam int RESET_CYCLES = 10;
    localparam int MAX_STEPS    = 48;
    localparam int NUM_TESTS    = 6;
    localparam int TIMEOUT_NS   = NUM_TESTS * (RESET_CYCLES + MAX_STEPS + 6) * 8 + 400;

    logic                 clk;
    logic                 rst;
    cpuPkg::word_t        Instr;
    cpuPkg::word_t        Pc;
    logic                 Halt;
    logic                 Err;
    logic                 RegWriteEn;
    cpuPkg::regSel_t      RegWriteSel;
    cpuPkg::word_t        RegWriteData;

    logic [31:0]          lfsrState;
    cpuPkg::word_t        prog [64];
    int                   progLen;
    cpuPkg::word_t        shadowRegs [8];
    cpuPkg::word_t        shadowMem [`DMEM_WORDS];
    cpuPkg::word_t        modelPc;
    int                   errCount;
    int                   passCount;
    int                   failCount;

    // outputs of the reference model for the current instruction
    logic                 expWe;
    cpuPkg::regSel_t      expSel;
    cpuPkg::word_t        expData;
    cpuPkg::word_t        expNext;
    logic                 expHalt;
    logic                 expErr;
    logic                 expStore;
    int                   storeAddr;
    cpuPkg::word_t        storeData;

    cpuTop UUT (
        .clk          (clk),
        .rst          (rst),
        .Instr        (Instr),
        .Pc           (Pc),
        .Halt         (Halt),
        .Err          (Err),
        .RegWriteEn   (RegWriteEn),
        .RegWriteSel  (RegWriteSel),
        .RegWriteData (RegWriteData)
    );

    always #4 clk = ~clk;

    // ##################################################
    // random bits and instruction encoding
    // ##################################################
    function automatic logic takeBit();
        logic b;
        b = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (b) lfsrState = lfsrState ^ 32'hA300_0000;  // galois taps
        return b;
    endfunction

    function automatic int randBits(input int n);
        int r;
        r = 0;
        for (int i = 0; i < n; i++) r = (r << 1) | int'(takeBit());
        return r;
    endfunction

    function automatic cpuPkg::word_t encI1(input logic [4:0] op, input logic [2:0] rs,
                                            input logic [2:0] rt, input logic [4:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic cpuPkg::word_t encI2(input logic [4:0] op, input logic [2:0] rs,
                                            input logic [7:0] imm);
        return {op, rs, imm};
    endfunction

    function automatic cpuPkg::word_t encR(input logic [4:0] op, input logic [2:0] rs,
                                           input logic [2:0] rt, input logic [2:0] rd,
                                           input logic [1:0] func);
        return {op, rs, rt, rd, func};
    endfunction

    task automatic clearProgram();
        for (int i = 0; i < 64; i++) prog[i] = {`OP_HALT, 11'b0};
        progLen = 0;
    endtask

    task automatic addInstr(input cpuPkg::word_t w);
        prog[progLen] = w;
        progLen++;
    endtask

    // ##################################################
    // reference model
    // ##################################################
    task automatic predict(input cpuPkg::word_t ins, input cpuPkg::word_t pc);
        logic [4:0]    op;
        cpuPkg::word_t a;
        cpuPkg::word_t b;
        cpuPkg::word_t s5;
        cpuPkg::word_t s8;
        cpuPkg::word_t addr;
        op = ins[15:11];
        a  = shadowRegs[ins[10:8]];
        b  = shadowRegs[ins[7:5]];
        s5 = {{11{ins[4]}}, ins[4:0]};
        s8 = {{8{ins[7]}}, ins[7:0]};
        addr = a + s5;
        expWe = 1'b0;
        expSel = ins[7:5];
        expData = '0;
        expNext = pc + 16'd2;
        expHalt = 1'b0;
        expErr = 1'b0;
        expStore = 1'b0;
        storeAddr = (addr >> 1) % `DMEM_WORDS;
        storeData = b;
        case (op)
            `OP_HALT: expHalt = 1'b1;
            `OP_NOP: ;
            `OP_ADDI: begin expWe = 1'b1; expData = a + s5; end
            `OP_SUBI: begin expWe = 1'b1; expData = s5 - a; end
            `OP_XORI: begin expWe = 1'b1; expData = a ^ s5; end
            `OP_ANDNI: begin expWe = 1'b1; expData = a & ~{11'b0, ins[4:0]}; end
            `OP_ST: expStore = 1'b1;
            `OP_LD: begin expWe = 1'b1; expData = shadowMem[storeAddr]; end
            `OP_LBI: begin expWe = 1'b1; expSel = ins[10:8]; expData = s8; end
            `OP_SLBI: begin expWe = 1'b1; expSel = ins[10:8]; expData = (a << 8) | ins[7:0]; end
            `OP_BEQZ: if (a == '0) expNext = pc + 16'd2 + s8;
            `OP_BNEZ: if (a != '0) expNext = pc + 16'd2 + s8;
            `OP_J: expNext = pc + 16'd2 + {{5{ins[10]}}, ins[10:0]};
            `OP_JR: expNext = a + s8;
            `OP_RTYPE: begin
                expWe = 1'b1;
                expSel = ins[4:2];
                case (ins[1:0])
                    `FUNC_ADD: expData = a + b;
                    `FUNC_SUB: expData = b - a;
                    `FUNC_XOR: expData = a ^ b;
                    default:   expData = a & ~b;
                endcase
            end
            `OP_SEQ: begin expWe = 1'b1; expSel = ins[4:2]; expData = {15'b0, a == b}; end
            `OP_SLT: begin
                expWe = 1'b1;
                expSel = ins[4:2];
                expData = {15'b0, $signed(a) < $signed(b)};
            end
            default: expErr = 1'b1;
        endcase
    endtask

    task automatic reportMismatch(input string what, input cpuPkg::word_t got,
                                  input cpuPkg::word_t want);
        $display("FAILED %0t: %s is %h, expected %h, instr %h", $time, what, got, want, Instr);
        errCount++;
    endtask

    task automatic checkStep();
        assert (Pc == modelPc) else reportMismatch("pc", Pc, modelPc);
        assert (Halt == expHalt) else reportMismatch("halt", 16'(Halt), 16'(expHalt));
        assert (Err == expErr) else reportMismatch("err", 16'(Err), 16'(expErr));
        assert (RegWriteEn == expWe)
            else reportMismatch("write enable", 16'(RegWriteEn), 16'(expWe));
        if (expWe) begin
            assert (RegWriteSel == expSel)
                else reportMismatch("write register", 16'(RegWriteSel), 16'(expSel));
            assert (RegWriteData == expData)
                else reportMismatch("write data", RegWriteData, expData);
        end
    endtask

    // ##################################################
    // program runner
    // ##################################################
    task automatic runProgram(input string name);
        int   steps;
        logic done;
        errCount = 0;
        steps = 0;
        done = 1'b0;
        @(posedge clk);
        #1 rst = 1'b1;
        Instr = {`OP_NOP, 11'b0};  // keeps the data memory quiet during reset
        repeat (RESET_CYCLES) @(posedge clk);
        #1 rst = 1'b0;
        modelPc = '0;
        while (!done && steps < MAX_STEPS) begin
            Instr = prog[Pc[6:1]];
            #2;
            predict(Instr, modelPc);
            checkStep();
            if (expHalt || expErr) begin
                done = 1'b1;
            end else begin
                if (expWe) shadowRegs[expSel] = expData;
                if (expStore) shadowMem[storeAddr] = storeData;
                modelPc = expNext;
            end
            steps++;
            @(posedge clk);
            #1;
        end
        if (!done) begin
            $display("test %s: the program never reached a halt", name);
            errCount++;
        end
        repeat (3) begin
            Instr = prog[Pc[6:1]];
            #2 checkStep();  // pc stays frozen on halt or an illegal opcode
            @(posedge clk);
            #1;
        end
        if (errCount == 0) begin
            $display("test %s: passed", name);
            passCount++;
        end else begin
            $display("test %s: %0d errors", name, errCount);
            failCount++;
        end
    endtask

    // ##################################################
    // tests
    // ##################################################
    task automatic immediateTest();
        logic [4:0] ops [6];
        int         k;
        ops = '{`OP_ADDI, `OP_SUBI, `OP_XORI, `OP_ANDNI, `OP_LBI, `OP_SLBI};
        clearProgram();
        for (int r = 0; r < 8; r++) addInstr(encI2(`OP_LBI, 3'(r), 8'(randBits(8))));
        for (int i = 0; i < 14; i++) begin
            k = randBits(3) % 6;
            if (k >= 4) addInstr(encI2(ops[k], 3'(randBits(3)), 8'(randBits(8))));
            else addInstr(encI1(ops[k], 3'(randBits(3)), 3'(randBits(3)), 5'(randBits(5))));
        end
        runProgram("immediate");
    endtask

    task automatic registerTest();
        int k;
        clearProgram();
        for (int r = 0; r < 8; r++) addInstr(encI2(`OP_SLBI, 3'(r), 8'(randBits(8))));
        for (int i = 0; i < 14; i++) begin
            k = randBits(3) % 6;
            if (k < 4) addInstr(encR(`OP_RTYPE, 3'(randBits(3)), 3'(randBits(3)),
                                     3'(randBits(3)), 2'(k)));
            else addInstr(encR((k == 4) ? `OP_SEQ : `OP_SLT, 3'(randBits(3)),
                               3'(randBits(3)), 3'(randBits(3)), 2'b00));
        end
        addInstr(encR(`OP_SEQ, 3'd1, 3'd1, 3'd2, 2'b00));
        runProgram("register");
    endtask

    task automatic memoryTest();
        logic [2:0] rs;
        logic [2:0] dest;
        logic [4:0] imm;
        clearProgram();
        for (int i = 0; i < 6; i++) begin
            rs = 3'(randBits(3));
            dest = 3'(randBits(3));
            imm = 5'(randBits(5));
            if (dest == rs) dest = rs + 3'd1;  // base register must survive the load
            addInstr(encI1(`OP_ST, rs, 3'(randBits(3)), imm));
            addInstr(encI1(`OP_LD, rs, dest, imm));
        end
        runProgram("memory");
    endtask

    task automatic branchTest();
        clearProgram();
        addInstr(encI2(`OP_LBI, 3'd1, 8'd0));
        addInstr(encI2(`OP_LBI, 3'd2, 8'd5));
        addInstr(encI2(`OP_BEQZ, 3'd1, 8'd2));   // taken, skips the halt
        addInstr({`OP_HALT, 11'b0});
        addInstr(encI2(`OP_BNEZ, 3'd1, 8'd2));   // not taken
        addInstr(encI2(`OP_BNEZ, 3'd2, 8'd2));   // taken
        addInstr({`OP_HALT, 11'b0});
        addInstr(encI2(`OP_BEQZ, 3'd2, 8'd4));   // not taken
        addInstr({`OP_J, 11'd2});
        addInstr({`OP_HALT, 11'b0});
        addInstr(encI2(`OP_LBI, 3'd3, 8'd30));
        addInstr(encI2(`OP_JR, 3'd3, 8'hFE));    // lands at pc 28
        addInstr({`OP_HALT, 11'b0});
        addInstr({`OP_HALT, 11'b0});
        addInstr(encI1(`OP_ADDI, 3'd1, 3'd4, 5'd1));
        runProgram("branch");
    endtask

    task automatic haltTest();
        clearProgram();
        addInstr(encI2(`OP_LBI, 3'd5, 8'(randBits(8))));
        addInstr({`OP_NOP, 11'b0});
        addInstr({`OP_HALT, 11'b0});
        runProgram("halt");
    endtask

    task automatic illegalTest();
        clearProgram();
        addInstr(encI2(`OP_LBI, 3'd6, 8'd7));
        addInstr(encI1(5'b00010, 3'd6, 3'd6, 5'd3));
        runProgram("illegal");
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        Instr = {`OP_NOP, 11'b0};
        lfsrState = 32'h8131_0e2c;
        passCount = 0;
        failCount = 0;
        immediateTest();
        registerTest();
        memoryTest();
        branchTest();
        haltTest();
        illegalTest();
        $display("%0d tests passed, %0d tests failed", passCount, failCount);
        if (failCount == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the tests did not finish in the expected time");
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- project.f
+incdir+design
design/cpuPkg.sv
design/regFile.sv
design/controlUnit.sv
design/decode.sv
design/aluExec.sv
design/memStage.sv
design/pcUnit.sv
design/cpuTop.sv
sim/cpuTop_chk.sv
sim/cpuTop_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = cpuTop_tb
FILELIST = project.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Simulation failed" $(LOG) || [ $$status -ne 0 ]; then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
